/* hw/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath and address width
`define XLEN 32

// architectural registers, x0 included
`define REG_COUNT 32

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// ecall is the system opcode with funct3 and funct12 both zero
`define ECALL_FUNCT3 3'b000
`define ECALL_FUNCT12 12'h000

`endif

/* hw/rv_isa_pkg.sv */
`include "rv_defs.svh"

package rv_isa_pkg;

  typedef logic [`XLEN-1:0] word_t;                 // data, address or instruction
  typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;
  typedef logic [2:0] funct3_t;
  typedef logic [3:0] byte_en_t;                    // one bit per byte lane

  // major opcodes, insn[6:0]
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b0000011,
    OP_STORE    = 7'b0100011,
    OP_BRANCH   = 7'b1100011,
    OP_JALR     = 7'b1100111,
    OP_MISC_MEM = 7'b0001111,
    OP_JAL      = 7'b1101111,
    OP_IMM      = 7'b0010011,
    OP_REG      = 7'b0110011,
    OP_SYSTEM   = 7'b1110011,
    OP_AUIPC    = 7'b0010111,
    OP_LUI      = 7'b0110111
  } opcode_t;

  // branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // load/store sizes
  localparam funct3_t F3_BYTE   = 3'b000;
  localparam funct3_t F3_HALF   = 3'b001;
  localparam funct3_t F3_WORD   = 3'b010;
  localparam funct3_t F3_BYTE_U = 3'b100;
  localparam funct3_t F3_HALF_U = 3'b101;

  // alu ops, shared by op and op-imm
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;  // srl or sra by insn[30]
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

endpackage

/* hw/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  // register write-back source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC4,   // link value of jal/jalr
    WB_IMM    // lui
  } wb_sel_t;

  typedef enum logic [1:0] {
    PC_SEQ,
    PC_BRANCH,  // taken only if the compare says so
    PC_JAL,
    PC_JALR
  } pc_sel_t;

endpackage

/* hw/rv_fetch.sv */
`timescale 1ns/1ns
`include "rv_defs.svh"

module rv_fetch import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  pc_sel_t pc_sel,
  input  logic    branch_taken,
  input  word_t   branch_target,  // pc + imm
  input  word_t   jump_target,    // rs1 + imm
  input  logic    is_ecall,
  output word_t   pc,
  output logic    halt
);

  word_t pc_plus4;
  word_t pc_next;

  assign pc_plus4 = pc + word_t'(4);

  always_comb begin
    case (pc_sel)
      PC_BRANCH: pc_next = branch_taken ? branch_target : pc_plus4;
      PC_JAL:    pc_next = branch_target;
      PC_JALR:   pc_next = {jump_target[`XLEN-1:1], 1'b0};  // low bit dropped
      default:   pc_next = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= `RESET_PC;
      halt <= 1'b0;
    end else if (!halt) begin
      pc   <= pc_next;
      halt <= is_ecall;  // sticky, never cleared until reset
    end
  end

  // targets come from execute, so a bad immediate shows up here
  assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

/* hw/rv_decode.sv */
`timescale 1ns/1ns
`include "rv_defs.svh"

module rv_decode import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  word_t    insn,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output word_t    imm,
  output alu_op_t  alu_op,
  output logic     use_imm,
  output logic     use_pc,
  output pc_sel_t  pc_sel,
  output wb_sel_t  wb_sel,
  output logic     reg_we,
  output logic     mem_load,
  output logic     mem_store,
  output logic     is_ecall,
  output funct3_t  funct3
);

  opcode_t opcode;
  logic    alt;      // insn[30], sub/sra select
  logic    we_raw;
  alu_op_t alu_fn;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_b;
  word_t   imm_j;
  word_t   imm_u;

  assign opcode = opcode_t'(insn[6:0]);
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign alt    = insn[30];

  // sign-extended immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // alu function for op and op-imm
  always_comb begin
    case (funct3)
      F3_ADD:  alu_fn = (opcode == OP_REG && alt) ? ALU_SUB : ALU_ADD;  // addi never subtracts
      F3_SLL:  alu_fn = ALU_SLL;
      F3_SLT:  alu_fn = ALU_SLT;
      F3_SLTU: alu_fn = ALU_SLTU;
      F3_XOR:  alu_fn = ALU_XOR;
      F3_SR:   alu_fn = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   alu_fn = ALU_OR;
      default: alu_fn = ALU_AND;
    endcase
  end

  always_comb begin
    imm       = '0;
    alu_op    = ALU_ADD;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    pc_sel    = PC_SEQ;
    wb_sel    = WB_ALU;
    we_raw    = 1'b0;
    mem_load  = 1'b0;
    mem_store = 1'b0;
    is_ecall  = 1'b0;
    case (opcode)
      OP_LUI: begin
        imm    = imm_u;
        wb_sel = WB_IMM;
        we_raw = 1'b1;
      end
      OP_AUIPC: begin
        imm     = imm_u;
        use_pc  = 1'b1;
        use_imm = 1'b1;
        we_raw  = 1'b1;
      end
      OP_JAL: begin
        imm    = imm_j;
        pc_sel = PC_JAL;
        wb_sel = WB_PC4;
        we_raw = 1'b1;
      end
      OP_JALR: begin
        imm    = imm_i;
        pc_sel = PC_JALR;
        wb_sel = WB_PC4;
        we_raw = 1'b1;
      end
      OP_BRANCH: begin
        imm    = imm_b;
        pc_sel = PC_BRANCH;
      end
      OP_LOAD: begin
        imm      = imm_i;
        use_imm  = 1'b1;
        mem_load = 1'b1;
        wb_sel   = WB_LOAD;
        we_raw   = 1'b1;
      end
      OP_STORE: begin
        imm       = imm_s;
        use_imm   = 1'b1;
        mem_store = 1'b1;
      end
      OP_IMM: begin
        imm     = imm_i;  // shamt sits in imm[4:0]
        use_imm = 1'b1;
        alu_op  = alu_fn;
        we_raw  = 1'b1;
      end
      OP_REG: begin
        alu_op = alu_fn;
        we_raw = 1'b1;
      end
      OP_MISC_MEM: ;  // fence, nothing to order here
      OP_SYSTEM: is_ecall = (funct3 == `ECALL_FUNCT3) && (insn[31:20] == `ECALL_FUNCT12);
      default: ;      // unknown opcode runs as a nop
    endcase
  end

  // x0 writes dropped here
  assign reg_we = we_raw && (rd != '0);

endmodule

/* hw/rv_regfile.sv */
`timescale 1ns/1ns
`include "rv_defs.svh"

module rv_regfile import rv_isa_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  logic     we,
  input  word_t    wdata,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[rd] <= wdata;  // decode never asks for rd == 0
    end
  end

  // combinational reads, x0 pinned to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hw/rv_execute.sv */
`timescale 1ns/1ns

module rv_execute import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  word_t   pc,
  input  word_t   rs1_data,
  input  word_t   rs2_data,
  input  word_t   imm,
  input  alu_op_t alu_op,
  input  logic    use_imm,
  input  logic    use_pc,
  input  funct3_t funct3,
  output word_t   alu_result,     // also the load/store address
  output word_t   branch_target,
  output word_t   jump_target,
  output logic    branch_taken
);

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign op_a  = use_pc ? pc : rs1_data;   // pc only for auipc
  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_SUB:  alu_result = op_a - op_b;
      ALU_SLL:  alu_result = op_a << shamt;
      ALU_SLT:  alu_result = word_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU: alu_result = word_t'(op_a < op_b);
      ALU_XOR:  alu_result = op_a ^ op_b;
      ALU_SRL:  alu_result = op_a >> shamt;
      ALU_SRA:  alu_result = word_t'($signed(op_a) >>> shamt);
      ALU_OR:   alu_result = op_a | op_b;
      ALU_AND:  alu_result = op_a & op_b;
      default:  alu_result = op_a + op_b;
    endcase
  end

  // branch compare always on the two registers
  assign lt_s = $signed(rs1_data) < $signed(rs2_data);
  assign lt_u = rs1_data < rs2_data;

  always_comb begin
    case (funct3)
      F3_BEQ:  branch_taken = rs1_data == rs2_data;
      F3_BNE:  branch_taken = rs1_data != rs2_data;
      F3_BLT:  branch_taken = lt_s;
      F3_BGE:  branch_taken = !lt_s;
      F3_BLTU: branch_taken = lt_u;
      F3_BGEU: branch_taken = !lt_u;
      default: branch_taken = 1'b0;  // 010/011 are not branches
    endcase
  end

  // branch and jal share the pc-relative adder
  assign branch_target = pc + imm;
  assign jump_target   = rs1_data + imm;

endmodule

/* hw/rv_mem_align.sv */
`timescale 1ns/1ns

module rv_mem_align import rv_isa_pkg::*; (
  input  word_t    addr,
  input  funct3_t  funct3,
  input  logic     mem_store,
  input  logic     mem_load,
  input  logic     halt,
  input  word_t    store_data,
  input  word_t    rdata,
  output word_t    dmem_addr,
  output byte_en_t dmem_be,
  output word_t    dmem_wdata,
  output word_t    load_value
);

  word_t      lane_shift;
  logic [7:0] ld_byte;
  logic [15:0] ld_half;

  assign dmem_addr = {addr[31:2], 2'b00};

  // stores: replicate data, pick lanes from size and offset
  always_comb begin
    case (funct3)
      F3_BYTE: begin
        dmem_wdata = {4{store_data[7:0]}};
        dmem_be    = byte_en_t'(4'b0001 << addr[1:0]);
      end
      F3_HALF: begin
        dmem_wdata = {2{store_data[15:0]}};
        dmem_be    = addr[1] ? 4'b1100 : 4'b0011;
      end
      F3_WORD: begin
        dmem_wdata = store_data;
        dmem_be    = 4'b1111;
      end
      default: begin
        dmem_wdata = store_data;
        dmem_be    = '0;
      end
    endcase
    if (!mem_store || halt) dmem_be = '0;  // no strobe unless a live store
  end

  // loads: move the addressed lane down, then extend
  assign lane_shift = rdata >> {addr[1:0], 3'b000};
  assign ld_byte    = lane_shift[7:0];
  assign ld_half    = addr[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (funct3)
      F3_BYTE:   load_value = {{24{ld_byte[7]}}, ld_byte};
      F3_BYTE_U: load_value = {24'b0, ld_byte};
      F3_HALF:   load_value = {{16{ld_half[15]}}, ld_half};
      F3_HALF_U: load_value = {16'b0, ld_half};
      default:   load_value = rdata;
    endcase
  end

  // natural alignment of the address the alu produced
  always_comb begin
    if ((mem_load || mem_store) && !halt) begin
      if (funct3 == F3_HALF || funct3 == F3_HALF_U)
        assert (addr[0] == 1'b0) else $error("misaligned halfword access at %h", addr);
      if (funct3 == F3_WORD)
        assert (addr[1:0] == 2'b00) else $error("misaligned word access at %h", addr);
    end
  end

endmodule

/* hw/rv_core.sv */
`timescale 1ns/1ns
`include "rv_defs.svh"

module rv_core import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  output word_t    imem_addr,
  input  word_t    imem_data,
  output word_t    dmem_addr,
  output word_t    dmem_wdata,
  output byte_en_t dmem_be,
  input  word_t    dmem_rdata,
  output logic     halt
);

  word_t    pc;
  word_t    pc_plus4;
  reg_idx_t rs1, rs2, rd;
  word_t    imm;
  alu_op_t  alu_op;
  logic     use_imm, use_pc;
  pc_sel_t  pc_sel;
  wb_sel_t  wb_sel;
  logic     reg_we, mem_load, mem_store, is_ecall;
  funct3_t  funct3;
  word_t    rs1_data, rs2_data;
  word_t    alu_result, branch_target, jump_target;
  logic     branch_taken;
  word_t    load_value;
  word_t    wb_data;

  assign imem_addr = pc;

  rv_fetch u_fetch (
    .clk(clk), .rst(rst), .pc_sel(pc_sel), .branch_taken(branch_taken),
    .branch_target(branch_target), .jump_target(jump_target),
    .is_ecall(is_ecall), .pc(pc), .halt(halt)
  );

  rv_decode u_decode (
    .insn(imem_data), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
    .use_imm(use_imm), .use_pc(use_pc), .pc_sel(pc_sel), .wb_sel(wb_sel),
    .reg_we(reg_we), .mem_load(mem_load), .mem_store(mem_store),
    .is_ecall(is_ecall), .funct3(funct3)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd), .we(reg_we),
    .wdata(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  rv_execute u_execute (
    .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .alu_op(alu_op),
    .use_imm(use_imm), .use_pc(use_pc), .funct3(funct3), .alu_result(alu_result),
    .branch_target(branch_target), .jump_target(jump_target),
    .branch_taken(branch_taken)
  );

  rv_mem_align u_mem_align (
    .addr(alu_result), .funct3(funct3), .mem_store(mem_store), .mem_load(mem_load),
    .halt(halt), .store_data(rs2_data), .rdata(dmem_rdata), .dmem_addr(dmem_addr),
    .dmem_be(dmem_be), .dmem_wdata(dmem_wdata), .load_value(load_value)
  );

  assign pc_plus4 = pc + word_t'(4);  // link value

  always_comb begin
    case (wb_sel)
      WB_LOAD: wb_data = load_value;
      WB_PC4:  wb_data = pc_plus4;
      WB_IMM:  wb_data = imm;
      default: wb_data = alu_result;
    endcase
  end

endmodule

/* verif/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// major opcodes the program builder needs
localparam int OPC_LOAD  = 'h03;
localparam int OPC_IMM   = 'h13;
localparam int OPC_AUIPC = 'h17;
localparam int OPC_LUI   = 'h37;
localparam int OPC_JALR  = 'h67;

function automatic word_t r_type(input int f7, input int rs2, input int rs1, input int f3,
                                 input int rd);
  return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic word_t i_type(input int imm, input int rs1, input int f3, input int rd,
                                 input int op);
  return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

function automatic word_t s_type(input int imm, input int rs2, input int rs1, input int f3);
  return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
endfunction

function automatic word_t b_type(input int imm, input int rs2, input int rs1, input int f3);
  return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic word_t u_type(input int imm20, input int rd, input int op);
  return {imm20[19:0], rd[4:0], op[6:0]};
endfunction

function automatic word_t j_type(input int imm, input int rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

task automatic emit(input word_t insn);
  image[prog_pc / 4] = insn;
  prog_pc += 4;
endtask

// sw to the next result slot off x2, with the value it must carry
task automatic store_word(input int rs, input word_t expected);
  emit(s_type(res_off, rs, 2, 2));
  exp_addr.push_back(word_t'(RESULT_BASE + res_off));
  exp_be.push_back(4'b1111);
  exp_data.push_back(expected);
  res_off += 4;
endtask

task automatic alu_r(input int f7, input int f3, input int rs1, input int rs2,
                     input word_t expected);
  emit(r_type(f7, rs2, rs1, f3, 5));
  store_word(5, expected);
endtask

task automatic alu_i(input int f3, input int rs1, input int imm, input word_t expected);
  emit(i_type(imm, rs1, f3, 5, OPC_IMM));
  store_word(5, expected);
endtask

// marker 0x100+id survives only when the branch skips the overwrite
task automatic branch_case(input int f3, input int rs1, input int rs2, input int taken,
                           input int id);
  emit(i_type('h100 + id, 0, 0, 6, OPC_IMM));
  emit(b_type(8, rs2, rs1, f3));
  emit(i_type('h200 + id, 0, 0, 6, OPC_IMM));  // fall-through path only
  store_word(6, word_t'(taken != 0 ? 'h100 + id : 'h200 + id));
endtask

task automatic load_case(input int f3, input int off);
  emit(i_type(off, 1, f3, 10, OPC_LOAD));
  store_word(10, load_expect(data_copy[off / 4], f3, off % 4));
endtask

// sb/sh of x11 = 0x12345678 into the data words, tracked in data_copy
task automatic part_store(input int f3, input int off);
  int       lane;
  byte_en_t be;
  word_t    data;
  lane = off % 4;
  if (f3 == 0) begin
    be   = byte_en_t'(1 << lane);
    data = word_t'(32'h78) << (8 * lane);
  end else begin
    be   = (lane >= 2) ? 4'b1100 : 4'b0011;
    data = word_t'(32'h5678) << (16 * (lane / 2));
  end
  emit(s_type(off, 11, 1, f3));
  data_copy[off / 4] = (data_copy[off / 4] & ~lane_mask(be)) | data;
  exp_addr.push_back(word_t'(DATA_BASE + off - lane));
  exp_be.push_back(be);
  exp_data.push_back(data);
endtask

task automatic build_program();
  int here;
  prog_pc = 0;
  res_off = 0;
  for (int i = 0; i < 16; i++) begin
    data_copy[i] = image[DATA_BASE / 4 + i];
  end
  emit(i_type(DATA_BASE, 0, 0, 1, OPC_IMM));
  emit(i_type(RESULT_BASE, 0, 0, 2, OPC_IMM));
  emit(i_type(-5, 0, 0, 3, OPC_IMM));
  emit(i_type(7, 0, 0, 4, OPC_IMM));
  alu_r('h00, 0, 3, 4, 32'h0000_0002);  // add
  alu_r('h20, 0, 3, 4, 32'hffff_fff4);  // sub
  alu_r('h00, 1, 4, 4, 32'h0000_0380);  // sll
  alu_r('h00, 2, 3, 4, 32'h0000_0001);  // slt
  alu_r('h00, 3, 3, 4, 32'h0000_0000);  // sltu, -5 is huge unsigned
  alu_r('h00, 4, 3, 4, 32'hffff_fffc);  // xor
  alu_r('h00, 5, 3, 4, 32'h01ff_ffff);  // srl
  alu_r('h20, 5, 3, 4, 32'hffff_ffff);  // sra
  alu_r('h00, 6, 3, 4, 32'hffff_ffff);  // or
  alu_r('h00, 7, 3, 4, 32'h0000_0003);  // and
  alu_i(0, 3, 'h123, 32'h0000_011e);
  alu_i(2, 3, 0, 32'h0000_0001);
  alu_i(3, 4, -1, 32'h0000_0001);       // sltiu against 0xffffffff
  alu_i(4, 3, 'h0f0, 32'hffff_ff0b);
  alu_i(1, 4, 28, 32'h7000_0000);
  alu_i(5, 3, 4, 32'h0fff_ffff);
  alu_i(5, 3, 'h401, 32'hffff_fffd);    // srai, bit 30 set
  emit(u_type('habcde, 5, OPC_LUI));
  store_word(5, 32'habcd_e000);
  here = prog_pc;
  emit(u_type(1, 5, OPC_AUIPC));
  store_word(5, word_t'(here + 'h1000));
  emit(32'h0000_000f);  // fence
  branch_case(0, 3, 3, 1, 0);
  branch_case(0, 3, 4, 0, 1);
  branch_case(1, 3, 4, 1, 2);
  branch_case(1, 4, 4, 0, 3);
  branch_case(4, 3, 4, 1, 4);
  branch_case(4, 4, 3, 0, 5);
  branch_case(5, 4, 3, 1, 6);
  branch_case(5, 3, 4, 0, 7);
  branch_case(6, 4, 3, 1, 8);
  branch_case(6, 3, 4, 0, 9);
  branch_case(7, 3, 4, 1, 10);
  branch_case(7, 4, 3, 0, 11);
  here = prog_pc;
  emit(j_type(8, 7));
  emit(i_type(0, 0, 0, 7, OPC_IMM));   // skipped, would clear the link
  store_word(7, word_t'(here + 4));
  here = prog_pc;
  emit(u_type(0, 8, OPC_AUIPC));
  emit(i_type(13, 8, 0, 9, OPC_JALR)); // odd target
  emit(i_type(0, 0, 0, 9, OPC_IMM));
  store_word(9, word_t'(here + 8));
  store_word(8, word_t'(here));
  for (int off = 0; off < 4; off++) begin
    load_case(0, off);
  end
  load_case(4, 5);
  load_case(4, 7);
  load_case(1, 10);
  load_case(5, 12);
  load_case(2, 16);
  emit(u_type('h12345, 11, OPC_LUI));
  emit(i_type('h678, 11, 0, 11, OPC_IMM));
  part_store(0, 21);
  part_store(0, 23);
  part_store(1, 26);
  part_store(1, 28);
  part_store(0, 30);
  load_case(2, 20);
  load_case(2, 24);
  load_case(2, 28);
  emit(32'h0000_0073);  // ecall
  emit(s_type(0, 3, 2, 2));  // parked behind the ecall, never strobes
endtask

`endif

/* verif/tb_rv_core.sv */
`timescale 1ns/1ns
`include "rv_defs.svh"

module tb_rv_core import rv_isa_pkg::*; ();

  localparam word_t SEED        = 32'h6462;
  localparam int    WAIT_LIMIT  = 100;    // cycles per wait loop
  localparam int    MEM_WORDS   = 1024;
  localparam int    DATA_BASE   = 'h400;  // random preload from here up
  localparam int    RESULT_BASE = 'h600;  // sw results land here

  logic     clk;
  logic     rst;
  word_t    imem_addr;
  word_t    imem_data;
  word_t    dmem_addr;
  word_t    dmem_wdata;
  byte_en_t dmem_be;
  word_t    dmem_rdata;
  logic     halt;

  word_t    mem [MEM_WORDS];
  word_t    image [MEM_WORDS];  // copied into mem while in reset
  word_t    data_copy [16];     // expected contents of the first data words
  word_t    exp_addr [$];
  byte_en_t exp_be [$];
  word_t    exp_data [$];
  int       prog_pc;
  int       res_off;

  rv_core dut0 (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_be(dmem_be),
    .dmem_rdata(dmem_rdata), .halt(halt)
  );

  always #10 clk = ~clk;

  // combinational reads for both ports
  assign imem_data  = mem[imem_addr[11:2]];
  assign dmem_rdata = mem[dmem_addr[11:2]];

  always @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem[w] <= image[w];
      end
    end else begin
      for (int l = 0; l < 4; l++) begin
        if (dmem_be[l]) begin
          mem[dmem_addr[11:2]][8*l +: 8] <= dmem_wdata[8*l +: 8];
        end
      end
    end
  end

  function automatic word_t xorshift(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t lane_mask(input byte_en_t be);
    word_t m;
    for (int l = 0; l < 4; l++) begin
      m[8*l +: 8] = {8{be[l]}};
    end
    return m;
  endfunction

  // value a load leaves in rd, funct3 picks size and extension
  function automatic word_t load_expect(input word_t w, input int f3, input int lane);
    logic [7:0]  b;
    logic [15:0] h;
    word_t       r;
    b = w[8*lane +: 8];
    h = w[16*(lane/2) +: 16];
    case (f3)
      0:       r = {{24{b[7]}}, b};
      4:       r = {24'b0, b};
      1:       r = {{16{h[15]}}, h};
      5:       r = {16'b0, h};
      default: r = w;
    endcase
    return r;
  endfunction

  task automatic stop_failed();
    $display("*** FAILED ***");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("FAIL %s: got %h, expected %h", name, actual, expected);
      stop_failed();
    end
  endtask

  task automatic wait_store();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (halt) begin
        $display("core halted before all expected stores were seen");
        stop_failed();
      end
      if (cycles > WAIT_LIMIT) begin
        $display("timed out waiting for a store strobe");
        stop_failed();
      end
    end while (dmem_be == '0);
  endtask

  task automatic wait_halt();
    int cycles;
    cycles = 0;
    while (!halt) begin
      @(negedge clk);
      cycles++;
      if (dmem_be != '0) begin
        $display("store strobe seen after the last expected store");
        stop_failed();
      end
      if (cycles > WAIT_LIMIT) begin
        $display("timed out waiting for halt after ECALL");
        stop_failed();
      end
    end
  endtask

  `include "tb_program.svh"

  initial begin
    word_t rng;
    word_t held_pc;
    clk = 1'b0;
    rst = 1'b1;
    rng = SEED;
    for (int i = 0; i < MEM_WORDS; i++) begin
      rng = xorshift(rng);
      image[i] = (i >= DATA_BASE / 4) ? rng : '0;  // zero words decode as nops
    end
    build_program();

    repeat (5) @(negedge clk);
    check("imem_addr", imem_addr, `RESET_PC);
    check("halt", word_t'(halt), '0);
    check("dmem_be", word_t'(dmem_be), '0);
    rst = 1'b0;

    // one row per expected store, in program order
    for (int i = 0; i < exp_addr.size(); i++) begin
      wait_store();
      check("dmem_addr", dmem_addr, exp_addr[i]);
      check("dmem_be", word_t'(dmem_be), word_t'(exp_be[i]));
      check("dmem_wdata", dmem_wdata & lane_mask(dmem_be), exp_data[i]);
    end

    wait_halt();
    held_pc = imem_addr;
    repeat (10) begin
      @(negedge clk);
      check("imem_addr", imem_addr, held_pc);  // frozen once halted
      check("dmem_be", word_t'(dmem_be), '0);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* project.f */
+incdir+hw
+incdir+verif
hw/rv_isa_pkg.sv
hw/rv_ctrl_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_mem_align.sv
hw/rv_core.sv
verif/tb_rv_core.sv

/* Makefile */
TOP = tb_rv_core

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f $(wildcard hw/*) $(wildcard verif/*)
	verilator --binary --timing --assert -j 0 -f project.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only -Wall -Ihw hw/rv_isa_pkg.sv hw/rv_ctrl_pkg.sv \
	  hw/rv_fetch.sv hw/rv_decode.sv hw/rv_regfile.sv hw/rv_execute.sv \
	  hw/rv_mem_align.sv hw/rv_core.sv --top-module rv_core

clean:
	rm -rf obj_dir
